// File: include/riscv_cfg.svh
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
// Also used as the pipeline bubble
`define INSTR_NOP 32'h0000_0013

// Only CSR the core writes, mirrored on the csr port
`define CSR_TOHOST 12'h51E

// Architectural integer registers
`define NUM_REGS 32

`endif

// File: rtl/riscv_pkg.sv
package riscv_pkg;

  // RV32I major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_t;

  // One instruction word, six field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_t    opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_t     opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      opcode_t    opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      opcode_t    opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      opcode_t     opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      opcode_t    opcode;
    } j_fmt;
  } instr_t;

  // Opcodes that write rd at writeback
  function automatic logic writes_rd(opcode_t opcode);
    case (opcode)
      OPC_LUI, OPC_OP_IMM, OPC_OP, OPC_LOAD, OPC_JAL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

// File: rtl/regfile.sv
`include "riscv_cfg.svh"

module regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic        we,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  input  logic [4:0]  wa,
  input  logic [31:0] wd,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [0:`NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // x0 first, then the same-cycle write, then the array
  assign rd1 = (ra1 == 5'd0) ? 32'd0 : (we && ra1 == wa) ? wd : regs[ra1];
  assign rd2 = (ra2 == 5'd0) ? 32'd0 : (we && ra2 == wa) ? wd : regs[ra2];

  // Writeback decode already drops rd == x0
  x0_write_blocked: assert property (@(posedge clk) disable iff (rst)
    !(we && wa == 5'd0));

endmodule

// File: rtl/fetch_decode.sv
`include "riscv_cfg.svh"

module fetch_decode (
  input  logic              clk,
  input  logic              rst,
  input  logic              pc_redirect,
  input  logic [31:0]       pc_target,
  input  logic [31:0]       icache_dout,
  output logic [31:0]       icache_addr,
  output logic [31:0]       pc_out,
  output riscv_pkg::instr_t instruction_out,
  output logic [31:0]       immediate_out
);
  import riscv_pkg::*;

  // Sequential fetch address when execute does not redirect
  logic [31:0] fetch_pc;
  // Low while the word on icache_dout was not fetched out of reset
  logic        fetch_valid;

  // Redirect goes straight to the memory, so a taken transfer costs one slot
  assign icache_addr = pc_redirect ? pc_target : fetch_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc    <= `RESET_PC;
      fetch_valid <= 1'b0;
    end else begin
      fetch_pc    <= icache_addr + 32'd4;
      fetch_valid <= 1'b1;
    end
  end

  // Address of the word arriving next cycle
  always_ff @(posedge clk) begin
    pc_out <= icache_addr;
  end

  assign instruction_out = fetch_valid ? icache_dout : `INSTR_NOP;

  always_comb begin
    case (instruction_out.r_fmt.opcode)
      OPC_STORE: begin
        immediate_out = {{20{instruction_out.s_fmt.imm_hi[6]}},
                         instruction_out.s_fmt.imm_hi, instruction_out.s_fmt.imm_lo};
      end
      OPC_BRANCH: begin
        immediate_out = {{20{instruction_out.b_fmt.imm_12}}, instruction_out.b_fmt.imm_11,
                         instruction_out.b_fmt.imm_10_5, instruction_out.b_fmt.imm_4_1, 1'b0};
      end
      OPC_LUI: begin
        immediate_out = {instruction_out.u_fmt.imm_31_12, 12'd0};
      end
      OPC_JAL: begin
        immediate_out = {{12{instruction_out.j_fmt.imm_20}}, instruction_out.j_fmt.imm_19_12,
                         instruction_out.j_fmt.imm_11, instruction_out.j_fmt.imm_10_1, 1'b0};
      end
      // OP_IMM, LOAD and SYSTEM all use the I layout
      default: begin
        immediate_out = {{20{instruction_out.i_fmt.imm[11]}}, instruction_out.i_fmt.imm};
      end
    endcase
  end

  // Branch and jump offsets are expected to keep word alignment
  fetch_aligned: assert property (@(posedge clk) disable iff (rst)
    icache_addr[1:0] == 2'b00);

endmodule

// File: rtl/execute.sv
`include "riscv_cfg.svh"

module execute (
  input  logic              clk,
  input  logic              rst,
  input  logic [31:0]       pc,
  input  logic [31:0]       rs1,
  input  logic [31:0]       rs2,
  input  logic [31:0]       immediate,
  input  logic [31:0]       wb_value,
  input  riscv_pkg::instr_t instruction,
  input  logic              a_forward,
  input  logic              b_forward,
  output logic [31:0]       alu_result,
  output logic [31:0]       pc_target,
  output logic [31:0]       dcache_din,
  output logic [31:0]       csr,
  output logic              pc_redirect,
  output logic [3:0]        dcache_we
);
  import riscv_pkg::*;

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [31:0] src_a;
  logic [31:0] src_b;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        use_imm;
  alu_op_t     alu_op;
  logic [1:0]  byte_off;

  // funct3 decode shared by register and immediate forms
  function automatic alu_op_t funct_op(logic [2:0] f3, logic alt);
    case (f3)
      3'b000: return alt ? ALU_SUB : ALU_ADD;
      3'b001: return ALU_SLL;
      3'b010: return ALU_SLT;
      3'b100: return ALU_XOR;
      3'b101: return ALU_SRL;
      3'b110: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = instruction.r_fmt.opcode;
  assign funct3 = instruction.r_fmt.funct3;

  // Writeback result of the previous instruction wins over the register read
  assign src_a = a_forward ? wb_value : rs1;
  assign src_b = b_forward ? wb_value : rs2;

  always_comb begin
    alu_op  = ALU_ADD;
    use_imm = 1'b1;
    case (opcode)
      OPC_LUI:    alu_op = ALU_PASS_B;
      OPC_OP_IMM: alu_op = funct_op(funct3, 1'b0);
      OPC_OP: begin
        use_imm = 1'b0;
        alu_op  = funct_op(funct3, instruction.r_fmt.funct7[5]);
      end
      OPC_BRANCH: use_imm = 1'b0;
      default: ;
    endcase
  end

  // JAL links through the ALU as pc + 4
  assign op_a = (opcode == OPC_JAL) ? pc : src_a;
  assign op_b = (opcode == OPC_JAL) ? 32'd4 : use_imm ? immediate : src_b;

  always_comb begin
    case (alu_op)
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SLT:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLL:    alu_result = op_a << op_b[4:0];
      ALU_SRL:    alu_result = op_a >> op_b[4:0];
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // BEQ has funct3 000, BNE 001
  assign pc_target   = pc + immediate;
  assign pc_redirect = (opcode == OPC_JAL) ||
                       (opcode == OPC_BRANCH && ((src_a == src_b) != funct3[0]));

  // Store lane select from the low address bits
  assign byte_off = alu_result[1:0];

  always_comb begin
    dcache_we  = 4'b0000;
    dcache_din = src_b;
    if (opcode == OPC_STORE) begin
      if (funct3[1]) begin
        dcache_we = 4'b1111;
      end else begin
        dcache_we  = 4'b0001 << byte_off;
        dcache_din = src_b << {byte_off, 3'b000};
      end
    end
  end

  // CSRRW to tohost, funct3 001
  always_ff @(posedge clk) begin
    if (rst) begin
      csr <= 32'd0;
    end else if (opcode == OPC_SYSTEM && funct3 == 3'b001 &&
                 instruction.i_fmt.imm == `CSR_TOHOST) begin
      csr <= src_a;
    end
  end

  // Full-word mask only at a word-aligned address
  store_mask_legal: assert property (@(posedge clk) disable iff (rst)
    $onehot0(dcache_we) || (dcache_we == 4'b1111 && alu_result[1:0] == 2'b00));

endmodule

// File: rtl/hazard_control.sv
module hazard_control (
  input  riscv_pkg::instr_t x_instruction,
  input  riscv_pkg::instr_t m_instruction,
  input  logic              pc_redirect,
  output logic              a_forward,
  output logic              b_forward,
  output logic              flush
);
  import riscv_pkg::*;

  logic       m_writes;
  logic [4:0] m_rd;

  assign m_rd     = m_instruction.r_fmt.rd;
  assign m_writes = writes_rd(m_instruction.r_fmt.opcode) && m_rd != 5'd0;

  // Sources of an instruction that has no rs field may match by accident
  // Execute ignores those operands, so no opcode check here
  assign a_forward = m_writes && (m_rd == x_instruction.r_fmt.rs1);
  assign b_forward = m_writes && (m_rd == x_instruction.r_fmt.rs2);

  // Only the decode slot is on the wrong path after a redirect
  assign flush = pc_redirect;

endmodule

// File: rtl/memory_writeback.sv
module memory_writeback (
  input  riscv_pkg::instr_t instruction,
  input  logic [31:0]       pc,
  input  logic [31:0]       alu_result,
  input  logic [31:0]       dcache_dout,
  output logic [31:0]       wb_value,
  output logic [4:0]        wb_reg,
  output logic              wb_enable
);
  import riscv_pkg::*;

  opcode_t     opcode;
  logic [31:0] lane_data;
  logic [31:0] load_value;

  assign opcode = instruction.r_fmt.opcode;

  // Move the addressed byte down to bits 7:0
  assign lane_data = dcache_dout >> {alu_result[1:0], 3'b000};

  // LBU is funct3 100, LW is 010
  assign load_value = instruction.i_fmt.funct3[2] ? {24'd0, lane_data[7:0]} : dcache_dout;

  always_comb begin
    case (opcode)
      OPC_LOAD: wb_value = load_value;
      OPC_JAL:  wb_value = pc + 32'd4;
      default:  wb_value = alu_result;
    endcase
  end

  assign wb_reg    = instruction.r_fmt.rd;
  assign wb_enable = writes_rd(opcode) && wb_reg != 5'd0;

endmodule

// File: rtl/riscv_core.sv
`include "riscv_cfg.svh"

module riscv_core (
  input  logic        clk,
  input  logic        rst,
  output logic [31:0] icache_addr,
  output logic        icache_re,
  input  logic [31:0] icache_dout,
  output logic [31:0] dcache_addr,
  output logic [3:0]  dcache_we,
  output logic        dcache_re,
  output logic [31:0] dcache_din,
  input  logic [31:0] dcache_dout,
  output logic [31:0] csr
);
  import riscv_pkg::*;

  // Decode stage
  logic [31:0] fd_pc;
  instr_t      fd_instruction;
  instr_t      fd_issue;
  logic [31:0] fd_immediate;
  logic [31:0] fd_rs1;
  logic [31:0] fd_rs2;

  // Execute stage
  logic [31:0] x_pc;
  instr_t      x_instruction;
  logic [31:0] x_rs1;
  logic [31:0] x_rs2;
  logic [31:0] x_immediate;
  logic [31:0] x_alu_result;
  logic [31:0] x_pc_target;
  logic        x_pc_redirect;

  // Memory/writeback stage
  logic [31:0] m_pc;
  instr_t      m_instruction;
  logic [31:0] m_alu_result;
  logic [31:0] wb_value;
  logic [4:0]  wb_reg;
  logic        wb_enable;

  logic a_forward;
  logic b_forward;
  logic flush;

  // Memories answer every cycle
  assign icache_re = 1'b1;
  assign dcache_re = 1'b1;

  regfile rf_i (
    .clk (clk),
    .rst (rst),
    .we  (wb_enable),
    .ra1 (fd_instruction.r_fmt.rs1),
    .ra2 (fd_instruction.r_fmt.rs2),
    .wa  (wb_reg),
    .wd  (wb_value),
    .rd1 (fd_rs1),
    .rd2 (fd_rs2)
  );

  fetch_decode fd_i (
    .clk             (clk),
    .rst             (rst),
    .pc_redirect     (x_pc_redirect),
    .pc_target       (x_pc_target),
    .icache_dout     (icache_dout),
    .icache_addr     (icache_addr),
    .pc_out          (fd_pc),
    .instruction_out (fd_instruction),
    .immediate_out   (fd_immediate)
  );

  assign fd_issue = flush ? `INSTR_NOP : fd_instruction;

  // Instruction registers carry the control state
  always_ff @(posedge clk) begin
    if (rst) begin
      x_instruction <= `INSTR_NOP;
      m_instruction <= `INSTR_NOP;
    end else begin
      x_instruction <= fd_issue;
      m_instruction <= x_instruction;
    end
  end

  always_ff @(posedge clk) begin
    x_pc         <= fd_pc;
    x_rs1        <= fd_rs1;
    x_rs2        <= fd_rs2;
    x_immediate  <= fd_immediate;
    m_pc         <= x_pc;
    m_alu_result <= x_alu_result;
  end

  execute ex_i (
    .clk         (clk),
    .rst         (rst),
    .pc          (x_pc),
    .rs1         (x_rs1),
    .rs2         (x_rs2),
    .immediate   (x_immediate),
    .wb_value    (wb_value),
    .instruction (x_instruction),
    .a_forward   (a_forward),
    .b_forward   (b_forward),
    .alu_result  (x_alu_result),
    .pc_target   (x_pc_target),
    .dcache_din  (dcache_din),
    .csr         (csr),
    .pc_redirect (x_pc_redirect),
    .dcache_we   (dcache_we)
  );

  // Data memory is addressed straight from the ALU
  assign dcache_addr = x_alu_result;

  hazard_control hz_i (
    .x_instruction (x_instruction),
    .m_instruction (m_instruction),
    .pc_redirect   (x_pc_redirect),
    .a_forward     (a_forward),
    .b_forward     (b_forward),
    .flush         (flush)
  );

  memory_writeback mwb_i (
    .instruction (m_instruction),
    .pc          (m_pc),
    .alu_result  (m_alu_result),
    .dcache_dout (dcache_dout),
    .wb_value    (wb_value),
    .wb_reg      (wb_reg),
    .wb_enable   (wb_enable)
  );

endmodule

// File: testbench/tb_memory.sv
`include "riscv_cfg.svh"

module tb_memory (
  input  logic        clk,
  input  logic [31:0] imem_addr,
  output logic [31:0] imem_dout,
  input  logic [31:0] dmem_addr,
  input  logic [3:0]  dmem_we,
  input  logic [31:0] dmem_din,
  output logic [31:0] dmem_dout
);

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];

  initial begin
    imem_dout = `INSTR_NOP;
    dmem_dout = 32'd0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = `INSTR_NOP;
      dmem[i] = 32'hC3A5_0000 ^ (i * 32'h0101_0107);
    end
  end

  // One-cycle synchronous reads
  always @(posedge clk) begin
    imem_dout <= imem[imem_addr[9:2]];
    dmem_dout <= dmem[dmem_addr[9:2]];
  end

  always @(posedge clk) begin
    if (dmem_we != 4'b0000) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_we[b]) begin
          dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_din[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: testbench/riscv_core_tb.sv
`include "riscv_cfg.svh"

module riscv_core_tb;

  logic        clk;
  logic        rst;
  logic [31:0] icache_addr;
  logic        icache_re;
  logic [31:0] icache_dout;
  logic [31:0] dcache_addr;
  logic [3:0]  dcache_we;
  logic        dcache_re;
  logic [31:0] dcache_din;
  logic [31:0] dcache_dout;
  logic [31:0] csr;

  // Reference model state
  logic [31:0] model_regs [0:`NUM_REGS-1];
  logic [31:0] model_mem [int];
  logic [31:0] csr_q [$];
  logic [31:0] st_addr_q [$];
  logic [3:0]  st_mask_q [$];
  logic [31:0] st_data_q [$];
  logic [31:0] last_expected_csr;
  logic [31:0] build_pc;
  logic [31:0] last_csr;
  int unsigned cycle_count;
  int unsigned run_cycles;
  int unsigned cycle_limit;
  bit          running;

  riscv_core dut_i (
    .clk         (clk),
    .rst         (rst),
    .icache_addr (icache_addr),
    .icache_re   (icache_re),
    .icache_dout (icache_dout),
    .dcache_addr (dcache_addr),
    .dcache_we   (dcache_we),
    .dcache_re   (dcache_re),
    .dcache_din  (dcache_din),
    .dcache_dout (dcache_dout),
    .csr         (csr)
  );

  tb_memory mem_i (
    .clk       (clk),
    .imem_addr (icache_addr),
    .imem_dout (icache_dout),
    .dmem_addr (dcache_addr),
    .dmem_we   (dcache_we),
    .dmem_din  (dcache_din),
    .dmem_dout (dcache_dout)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic value_mismatch(input string test, input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s expected %h actual %h", test, exp, act);
    $display(">>> FAIL");
    $fatal(1, "check %s failed", test);
  endtask

  task automatic run_error(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "%s", what);
  endtask

  // RV32I encodings
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_csrrw(logic [4:0] rs1);
    return {`CSR_TOHOST, rs1, 3'b001, 5'd0, 7'b1110011};
  endfunction

  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: return a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Executes one instruction on the model, in program order
  task automatic model_exec(input logic [31:0] w, input logic [31:0] pc, output bit tk);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] word;
    logic [1:0]  off;
    bit          wr;
    a = model_regs[w[19:15]];
    b = model_regs[w[24:20]];
    tk = 1'b0;
    wr = 1'b0;
    res = 32'd0;
    case (w[6:0])
      7'b0110111: begin
        res = {w[31:12], 12'd0};
        wr = 1'b1;
      end
      7'b0010011: begin
        res = alu_ref(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
        wr = 1'b1;
      end
      7'b0110011: begin
        res = alu_ref(w[14:12], w[30], a, b);
        wr = 1'b1;
      end
      7'b0000011: begin
        addr = a + {{20{w[31]}}, w[31:20]};
        word = model_mem[addr[31:2]];
        res = (w[14:12] == 3'b100) ? {24'd0, word[8*addr[1:0] +: 8]} : word;
        wr = 1'b1;
      end
      7'b0100011: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        off = addr[1:0];
        st_addr_q.push_back(addr);
        if (w[14:12] == 3'b010) begin
          st_mask_q.push_back(4'b1111);
          st_data_q.push_back(b);
          model_mem[addr[31:2]] = b;
        end else begin
          st_mask_q.push_back(4'b0001 << off);
          st_data_q.push_back({24'd0, b[7:0]} << (8 * off));
          word = model_mem[addr[31:2]];
          word[8*off +: 8] = b[7:0];
          model_mem[addr[31:2]] = word;
        end
      end
      7'b1100011: tk = (w[14:12] == 3'b000) ? (a == b) : (a != b);
      7'b1101111: begin
        res = pc + 32'd4;
        wr = 1'b1;
        tk = 1'b1;
      end
      7'b1110011: begin
        // Equal values leave csr unchanged, so nothing to see
        if (a != last_expected_csr) begin
          csr_q.push_back(a);
        end
        last_expected_csr = a;
      end
      default: ;
    endcase
    if (wr && w[11:7] != 5'd0) begin
      model_regs[w[11:7]] = res;
    end
  endtask

  task automatic place(input logic [31:0] w, input bit run, output bit tk);
    tk = 1'b0;
    mem_i.imem[build_pc[9:2]] = w;
    if (run) begin
      model_exec(w, build_pc, tk);
    end
    build_pc = build_pc + 32'd4;
  endtask

  task automatic put(input logic [31:0] w);
    bit tk;
    place(w, 1'b1, tk);
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    put({hi[19:0], rd, 7'b0110111});
    put(enc_i(v[11:0], rd, 3'b000, rd, 7'b0010011));
  endtask

  // Branch or jump followed by a CSRRW that runs only on fall-through
  task automatic transfer(input logic [31:0] w, input logic [4:0] follow_src);
    bit tk;
    place(w, 1'b1, tk);
    place(enc_csrrw(follow_src), !tk, tk);
  endtask

  task automatic build_program;
    logic [2:0] imm_ops [5];
    imm_ops = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
    build_pc = `RESET_PC;
    load_const(5'd1, $urandom);
    load_const(5'd2, $urandom);
    load_const(5'd20, 32'h0BAD_F00D);
    // Immediate and register ALU forms
    foreach (imm_ops[i]) begin
      put(enc_i(12'($urandom), 5'd1, imm_ops[i], 5'd5, 7'b0010011));
      put(enc_csrrw(5'd5));
    end
    for (int f = 0; f < 8; f++) begin
      // funct3 011 is SLTU, not in the supported set
      if (f != 3) begin
        put(enc_r(7'b0000000, 5'd2, 5'd1, f[2:0], 5'd5));
        put(enc_csrrw(5'd5));
      end
    end
    put(enc_r(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd5));
    put(enc_csrrw(5'd5));
    // Dependence chain ending in a load used at once
    put(enc_i(12'($urandom), 5'd1, 3'b000, 5'd6, 7'b0010011));
    put(enc_r(7'b0000000, 5'd2, 5'd6, 3'b000, 5'd6));
    put(enc_r(7'b0100000, 5'd1, 5'd6, 3'b000, 5'd7));
    put(enc_i(12'h100, 5'd0, 3'b000, 5'd10, 7'b0010011));
    put(enc_s(12'd0, 5'd7, 5'd10, 3'b010));
    put(enc_i(12'd0, 5'd10, 3'b010, 5'd8, 7'b0000011));
    put(enc_r(7'b0000000, 5'd8, 5'd8, 3'b000, 5'd9));
    put(enc_csrrw(5'd9));
    // Word store, then one byte into each lane
    put(enc_s(12'd4, 5'd1, 5'd10, 3'b010));
    for (int k = 0; k < 4; k++) begin
      put(enc_s(12'(8 + k), 5'd2, 5'd10, 3'b000));
      put(enc_i(12'd1, 5'd2, 3'b000, 5'd2, 7'b0010011));
    end
    put(enc_i(12'd4, 5'd10, 3'b010, 5'd11, 7'b0000011));
    put(enc_csrrw(5'd11));
    put(enc_i(12'd8, 5'd10, 3'b010, 5'd11, 7'b0000011));
    put(enc_csrrw(5'd11));
    for (int k = 0; k < 8; k++) begin
      put(enc_i(12'(4 + k), 5'd10, 3'b100, 5'd12, 7'b0000011));
      put(enc_csrrw(5'd12));
    end
    // Control transfers over a poisoned CSRRW
    transfer(enc_b(13'd8, 5'd1, 5'd1, 3'b000), 5'd20);
    put(enc_csrrw(5'd2));
    transfer(enc_b(13'd8, 5'd2, 5'd1, 3'b001), 5'd20);
    put(enc_csrrw(5'd1));
    transfer(enc_j(21'd8, 5'd21), 5'd20);
    put(enc_csrrw(5'd21));
    transfer(enc_b(13'd8, 5'd2, 5'd1, 3'b000), 5'd1);
    load_const(5'd22, 32'h1357_9BDF);
    put(enc_csrrw(5'd22));
    cycle_limit = 2 * (build_pc >> 2) + 50;
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= 2 && cycle_count <= 5) begin
      assert (icache_addr == `RESET_PC) else value_mismatch("reset_pc", `RESET_PC, icache_addr);
      assert (dcache_we == 4'b0000) else value_mismatch("reset_we", 32'd0, {28'd0, dcache_we});
      assert (csr == 32'd0) else value_mismatch("reset_csr", 32'd0, csr);
    end
    if (cycle_count >= 2) begin
      assert (icache_re == 1'b1) else value_mismatch("icache_re", 32'd1, {31'd0, icache_re});
      assert (dcache_re == 1'b1) else value_mismatch("dcache_re", 32'd1, {31'd0, dcache_re});
    end
    if (running) begin
      run_cycles = run_cycles + 1;
      if (run_cycles > cycle_limit) begin
        run_error("Run timed out before every expected result was seen");
      end
    end
    if (cycle_count >= 2 && dcache_we != 4'b0000) begin
      assert (st_addr_q.size() != 0) else run_error("Store seen with none expected");
      assert (dcache_addr == st_addr_q[0])
        else value_mismatch("store_addr", st_addr_q[0], dcache_addr);
      assert (dcache_we == st_mask_q[0])
        else value_mismatch("store_mask", {28'd0, st_mask_q[0]}, {28'd0, dcache_we});
      for (int b = 0; b < 4; b++) begin
        assert (!dcache_we[b] || dcache_din[8*b +: 8] == st_data_q[0][8*b +: 8])
          else value_mismatch("store_data", st_data_q[0], dcache_din);
      end
      void'(st_addr_q.pop_front());
      void'(st_mask_q.pop_front());
      void'(st_data_q.pop_front());
    end
    if (cycle_count >= 2 && csr !== last_csr) begin
      assert (csr_q.size() != 0) else run_error("csr changed with no value expected");
      assert (csr == csr_q[0]) else value_mismatch("csr_write", csr_q[0], csr);
      void'(csr_q.pop_front());
      last_csr = csr;
    end
  end

  initial begin
    rst = 1'b1;
    cycle_count = 0;
    run_cycles = 0;
    running = 1'b0;
    last_csr = 32'd0;
    last_expected_csr = 32'd0;
    for (int r = 0; r < `NUM_REGS; r++) begin
      model_regs[r] = 32'd0;
    end
    void'($urandom(39265));
    #1;
    build_program();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    running = 1'b1;
    while (csr_q.size() != 0 || st_addr_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
rtl/riscv_pkg.sv
rtl/regfile.sv
rtl/fetch_decode.sv
rtl/execute.sv
rtl/hazard_control.sv
rtl/memory_writeback.sv
rtl/riscv_core.sv
testbench/tb_memory.sv
testbench/riscv_core_tb.sv

// File: Bender.yml
package:
  name: riscv_core

export_include_dirs:
  - include

sources:
  - files:
      - rtl/riscv_pkg.sv
      - rtl/regfile.sv
      - rtl/fetch_decode.sv
      - rtl/execute.sv
      - rtl/hazard_control.sv
      - rtl/memory_writeback.sv
      - rtl/riscv_core.sv
  - target: test
    files:
      - testbench/tb_memory.sv
      - testbench/riscv_core_tb.sv
